/* hdl/cpl_pkg.sv */
package cpl_pkg;

  // tag and region geometry
  localparam int TAG_W    = 4;
  localparam int BEAT_W   = 5;
  localparam int NUM_TAGS = 1 << TAG_W;

  // payload and buffer word
  localparam int DATA_W    = 128;
  localparam int BUF_AW    = TAG_W + BEAT_W;
  localparam int BUF_DEPTH = 1 << BUF_AW;
  localparam int BUF_W     = DATA_W + 2;

  // end-of-packet flag position in a buffer word
  localparam int EOP_BIT = BUF_W - 1;

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [BEAT_W-1:0] beat_t;

  // upper field is the tag, lower field the beat index
  typedef logic [BUF_AW-1:0] buf_addr_t;

  typedef logic [DATA_W-1:0] data_t;

  // bit 129 eop, bit 128 spare, low bits payload
  typedef logic [BUF_W-1:0]  buf_word_t;

  // encodings let valid decode from the low bit
  typedef enum logic [2:0] {
    RXCPL_IDLE     = 3'h0,
    RXCPL_RDPIPE   = 3'h3,
    RXCPL_RD_VALID = 3'h5
  } rxcpl_state_t;

endpackage

/* hdl/cpl_tag_alloc.sv */
`timescale 1ns/1ps

module cpl_tag_alloc
  import cpl_pkg::*;
(
  input  logic AvlClk_i,
  input  logic Rstn_i,
  input  logic RdReq_i,
  input  logic TagRelease_i,
  output logic RdGrant_o,
  output tag_t RdTag_o
);

  tag_t             next_tag;
  logic [TAG_W:0]   out_cnt;
  logic             grant_take;

  // a tag is free while fewer than 16 reads are outstanding
  assign RdGrant_o  = out_cnt < (TAG_W + 1)'(NUM_TAGS);
  assign RdTag_o    = next_tag;
  assign grant_take = RdReq_i & RdGrant_o;

  // tags go out in strict rotation
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      next_tag <= '0;
    else if (grant_take)
      next_tag <= next_tag + 1'b1;
  end

  // outstanding read count
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      out_cnt <= '0;
    end
    else
    begin
      case ({grant_take, TagRelease_i})
        2'b10:
          out_cnt <= out_cnt + 1'b1;
        2'b01:
          out_cnt <= out_cnt - 1'b1;
        default:
          // grant and release together cancel out
          out_cnt <= out_cnt;
      endcase
    end
  end

endmodule

/* hdl/cpl_buf_ram.sv */
`timescale 1ns/1ps

module cpl_buf_ram
  import cpl_pkg::*;
(
  input  logic      AvlClk_i,
  input  logic      WrEn_i,
  input  buf_addr_t WrAddr_i,
  input  buf_word_t WrData_i,
  input  buf_addr_t RdAddr_i,
  output buf_word_t RdData_o
);

  // 16 regions of 32 beats, one region per tag
  buf_word_t mem [BUF_DEPTH];

  // write port
  always_ff @(posedge AvlClk_i)
  begin
    if (WrEn_i)
      mem[WrAddr_i] <= WrData_i;
  end

  // registered read, data one cycle after the address
  always_ff @(posedge AvlClk_i)
  begin
    RdData_o <= mem[RdAddr_i];
  end

endmodule

/* hdl/cpl_wr_ctrl.sv */
`timescale 1ns/1ps

module cpl_wr_ctrl
  import cpl_pkg::*;
(
  input  logic      AvlClk_i,
  input  logic      Rstn_i,
  input  logic      CplValid_i,
  input  tag_t      CplTag_i,
  input  data_t     CplData_i,
  input  logic      CplEnd_i,
  input  logic      CplLast_i,
  output logic      WrEn_o,
  output buf_addr_t WrAddr_o,
  output buf_word_t WrData_o,
  output logic      CplReq_o,
  output tag_t      CplDescTag_o,
  output logic      CplDescLast_o
);

  beat_t wr_ptr [NUM_TAGS];
  logic  cpl_end;
  logic  pkt_end;

  assign cpl_end = CplValid_i & CplEnd_i;

  // last beat of the final completion closes the region
  assign pkt_end = cpl_end & CplLast_i;

  // beat lands at the tag's region and its current pointer
  assign WrEn_o   = CplValid_i;
  assign WrAddr_o = {CplTag_i, wr_ptr[CplTag_i]};
  assign WrData_o = {pkt_end, 1'b0, CplData_i};

  // per-tag write pointers
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      for (int i = 0; i < NUM_TAGS; i++)
        wr_ptr[i] <= '0;
    end
    else if (CplValid_i)
    begin
      if (pkt_end)
        wr_ptr[CplTag_i] <= '0;
      else
        wr_ptr[CplTag_i] <= wr_ptr[CplTag_i] + 1'b1;
    end
  end

  // one descriptor pulse per completion end
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      CplReq_o <= 1'b0;
    else
      CplReq_o <= cpl_end;
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (cpl_end)
    begin
      CplDescTag_o  <= CplTag_i;
      CplDescLast_o <= CplLast_i;
    end
  end

endmodule

/* hdl/cpl_rx_resp.sv */
`timescale 1ns/1ps

module cpl_rx_resp
  import cpl_pkg::*;
(
  input  logic      AvlClk_i,
  input  logic      Rstn_i,
  input  logic      CplReq_i,
  input  tag_t      CplDescTag_i,
  input  logic      CplDescLast_i,
  output buf_addr_t CplRdAddr_o,
  input  buf_word_t CplBufData_i,
  output logic      TagRelease_o,
  output data_t     TxsReadData_o,
  output logic      TxsReadDataValid_o
);

  rxcpl_state_t          rxcpl_state;
  rxcpl_state_t          rxcpl_nxt_state;
  logic                  cpl_req_reg;
  logic                  cpl_req_rise;
  logic [NUM_TAGS-1:0]   last_cpl_reg;
  logic [NUM_TAGS-1:0]   tag_status_reg;
  tag_t                  hol_cntr;
  beat_t                 rd_addr_cntr;
  logic                  cpl_eop;
  logic                  cpl_done;
  logic                  hol_ready;
  logic                  idle_st;

  // descriptor strobe edge detect
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      cpl_req_reg <= 1'b0;
    else
      cpl_req_reg <= CplReq_i;
  end

  assign cpl_req_rise = CplReq_i & ~cpl_req_reg;

  assign cpl_eop   = CplBufData_i[EOP_BIT];
  assign idle_st   = (rxcpl_state == RXCPL_IDLE);
  assign hol_ready = tag_status_reg[hol_cntr];

  // per-tag status, set wins over clear
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      last_cpl_reg   <= '0;
      tag_status_reg <= '0;
    end
    else
    begin
      if (cpl_done)
      begin
        last_cpl_reg[hol_cntr]   <= 1'b0;
        tag_status_reg[hol_cntr] <= 1'b0;
      end
      if (cpl_req_rise)
      begin
        last_cpl_reg[CplDescTag_i] <= CplDescLast_i;
        if (CplDescLast_i)
          tag_status_reg[CplDescTag_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      rxcpl_state <= RXCPL_IDLE;
    else
      rxcpl_state <= rxcpl_nxt_state;
  end

  always_comb
  begin
    case (rxcpl_state)
      RXCPL_IDLE:
        rxcpl_nxt_state = hol_ready ? RXCPL_RDPIPE : RXCPL_IDLE;
      RXCPL_RDPIPE,
      RXCPL_RD_VALID:
        rxcpl_nxt_state = cpl_eop ? RXCPL_IDLE : RXCPL_RD_VALID;
      default:
        rxcpl_nxt_state = RXCPL_IDLE;
    endcase
  end

  // data is valid in both read states
  assign TxsReadDataValid_o = (rxcpl_state == RXCPL_RDPIPE) |
                              (rxcpl_state == RXCPL_RD_VALID);
  assign TxsReadData_o      = CplBufData_i[DATA_W-1:0];
  assign cpl_done           = TxsReadDataValid_o & cpl_eop;
  assign TagRelease_o       = cpl_done;

  // head of line follows request order
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      hol_cntr <= '0;
    else if (cpl_done & last_cpl_reg[hol_cntr])
      hol_cntr <= hol_cntr + 1'b1;
  end

  // beat counter runs one ahead of the data
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      rd_addr_cntr <= '0;
    else if (cpl_done)
      rd_addr_cntr <= '0;
    else if (TxsReadDataValid_o | (idle_st & hol_ready))
      rd_addr_cntr <= rd_addr_cntr + 1'b1;
  end

  assign CplRdAddr_o = {hol_cntr, rd_addr_cntr};

endmodule

/* hdl/cpl_read_top.sv */
`timescale 1ns/1ps

module cpl_read_top
  import cpl_pkg::*;
(
  input  logic  AvlClk_i,
  input  logic  Rstn_i,
  input  logic  RdReq_i,
  output logic  RdGrant_o,
  output tag_t  RdTag_o,
  input  logic  CplValid_i,
  input  tag_t  CplTag_i,
  input  data_t CplData_i,
  input  logic  CplEnd_i,
  input  logic  CplLast_i,
  output data_t TxsReadData_o,
  output logic  TxsReadDataValid_o
);

  logic      tag_release;
  logic      wr_en;
  buf_addr_t wr_addr;
  buf_word_t wr_data;
  logic      cpl_req;
  tag_t      cpl_desc_tag;
  logic      cpl_desc_last;
  buf_addr_t cpl_rd_addr;
  buf_word_t cpl_buf_data;

  cpl_tag_alloc u_tag_alloc (
    .AvlClk_i     (AvlClk_i),
    .Rstn_i       (Rstn_i),
    .RdReq_i      (RdReq_i),
    .TagRelease_i (tag_release),
    .RdGrant_o    (RdGrant_o),
    .RdTag_o      (RdTag_o)
  );

  cpl_wr_ctrl u_wr_ctrl (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .CplValid_i    (CplValid_i),
    .CplTag_i      (CplTag_i),
    .CplData_i     (CplData_i),
    .CplEnd_i      (CplEnd_i),
    .CplLast_i     (CplLast_i),
    .WrEn_o        (wr_en),
    .WrAddr_o      (wr_addr),
    .WrData_o      (wr_data),
    .CplReq_o      (cpl_req),
    .CplDescTag_o  (cpl_desc_tag),
    .CplDescLast_o (cpl_desc_last)
  );

  cpl_buf_ram u_buf_ram (
    .AvlClk_i (AvlClk_i),
    .WrEn_i   (wr_en),
    .WrAddr_i (wr_addr),
    .WrData_i (wr_data),
    .RdAddr_i (cpl_rd_addr),
    .RdData_o (cpl_buf_data)
  );

  cpl_rx_resp u_rx_resp (
    .AvlClk_i           (AvlClk_i),
    .Rstn_i             (Rstn_i),
    .CplReq_i           (cpl_req),
    .CplDescTag_i       (cpl_desc_tag),
    .CplDescLast_i      (cpl_desc_last),
    .CplRdAddr_o        (cpl_rd_addr),
    .CplBufData_i       (cpl_buf_data),
    .TagRelease_o       (tag_release),
    .TxsReadData_o      (TxsReadData_o),
    .TxsReadDataValid_o (TxsReadDataValid_o)
  );

endmodule

/* bench/cpl_read_assert.sv */
`timescale 1ns/1ps

module cpl_read_assert
  import cpl_pkg::*;
(
  input logic         AvlClk_i,
  input logic         Rstn_i,
  input rxcpl_state_t state_i,
  input logic         release_i,
  input logic         valid_i
);

  // state register only holds the three encodings
  state_legal: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    (state_i == RXCPL_IDLE) || (state_i == RXCPL_RDPIPE) || (state_i == RXCPL_RD_VALID))
    else $error("reader state outside its legal encodings");

  // release rides on the last valid beat and closes the burst
  release_with_valid: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    release_i |=> ($past(valid_i) && !valid_i))
    else $error("tag release not on the last beat of a read data burst");

  // first beat is followed by more data or the end of the packet
  pipe_next: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    (state_i == RXCPL_RDPIPE) |=>
      (valid_i || ((state_i == RXCPL_IDLE) && $past(release_i))))
    else $error("read pipe state not followed by valid data or a released packet");

endmodule

bind cpl_rx_resp cpl_read_assert u_rx_resp_assert (
  .AvlClk_i  (AvlClk_i),
  .Rstn_i    (Rstn_i),
  .state_i   (rxcpl_state),
  .release_i (TagRelease_o),
  .valid_i   (TxsReadDataValid_o)
);

/* bench/cpl_read_tb.sv */
`timescale 1ns/1ps

module cpl_read_tb
  import cpl_pkg::*;
();

  localparam int MAX_LEN     = 8;
  // worst case over all tests, 25 completions of up to 8 beats
  localparam int MAX_BEATS   = 25 * MAX_LEN;
  localparam int WDOG_CYCLES = MAX_BEATS * 20 + 2000;

  logic        avl_clk = 1'b0;
  logic        rstn;
  logic        rd_req;
  logic        rd_grant;
  tag_t        rd_tag;
  logic        cpl_valid;
  tag_t        cpl_tag;
  data_t       cpl_data;
  logic        cpl_end;
  logic        cpl_last;
  data_t       txs_data;
  logic        txs_valid;

  logic [15:0] lfsr_q = 16'd76;
  tag_t        exp_tag;
  data_t       exp_data_q[$];
  logic        exp_last_q[$];
  data_t       region_mem [NUM_TAGS][1 << BEAT_W];
  logic        mid_burst;
  logic        beat_last;

  always #20 avl_clk = ~avl_clk;

  cpl_read_top uut (
    .AvlClk_i           (avl_clk),
    .Rstn_i             (rstn),
    .RdReq_i            (rd_req),
    .RdGrant_o          (rd_grant),
    .RdTag_o            (rd_tag),
    .CplValid_i         (cpl_valid),
    .CplTag_i           (cpl_tag),
    .CplData_i          (cpl_data),
    .CplEnd_i           (cpl_end),
    .CplLast_i          (cpl_last),
    .TxsReadData_o      (txs_data),
    .TxsReadDataValid_o (txs_valid)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic data_t rand_data();
    data_t d;
    for (int i = 0; i < DATA_W; i++)
      d[i] = lfsr_bit();
    return d;
  endfunction

  // 1 to 8 beats from three bits
  function automatic int rand_len();
    logic [2:0] v;
    for (int i = 0; i < 3; i++)
      v[i] = lfsr_bit();
    return int'(v) + 1;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "run aborted");
  endtask

  task automatic check_data(input data_t act, input data_t exp, input string what);
    if (act !== exp)
      abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, act, exp));
  endtask

  task automatic check_tag(input tag_t act, input tag_t exp, input string what);
    if (act !== exp)
      abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, act, exp));
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp)
      abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, act, exp));
  endtask

  task automatic apply_reset();
    rstn      = 1'b0;
    rd_req    = 1'b0;
    cpl_valid = 1'b0;
    cpl_tag   = '0;
    cpl_data  = '0;
    cpl_end   = 1'b0;
    cpl_last  = 1'b0;
    exp_tag   = '0;
    repeat (4) @(negedge avl_clk);
    rstn = 1'b1;
  endtask

  // one request strobe, granted with the next tag in rotation
  task automatic request_read(output tag_t tag);
    @(negedge avl_clk);
    check_bit(rd_grant, 1'b1, "read grant");
    check_tag(rd_tag, exp_tag, "granted tag");
    tag    = rd_tag;
    rd_req = 1'b1;
    @(negedge avl_clk);
    rd_req  = 1'b0;
    exp_tag = exp_tag + 1'b1;
  endtask

  // fill a tag region and queue its beats in request order
  task automatic expect_region(input tag_t tag, input int len);
    for (int i = 0; i < len; i++)
    begin
      region_mem[tag][i] = rand_data();
      exp_data_q.push_back(region_mem[tag][i]);
      exp_last_q.push_back(i == len - 1);
    end
  endtask

  task automatic send_cpl(input tag_t tag, input int first, input int len, input logic last);
    for (int i = 0; i < len; i++)
    begin
      @(negedge avl_clk);
      cpl_valid = 1'b1;
      cpl_tag   = tag;
      cpl_data  = region_mem[tag][first + i];
      cpl_end   = (i == len - 1);
      cpl_last  = last && (i == len - 1);
    end
    // idle cycle after each end beat
    @(negedge avl_clk);
    cpl_valid = 1'b0;
    cpl_end   = 1'b0;
    cpl_last  = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data_q.size() != 0)
      @(negedge avl_clk);
    @(negedge avl_clk);
  endtask

  task automatic test_reset();
    for (int i = 0; i < 4; i++)
    begin
      @(negedge avl_clk);
      check_bit(rd_grant, 1'b1, "grant after reset");
      check_tag(rd_tag, '0, "tag after reset");
      check_bit(txs_valid, 1'b0, "read data valid after reset");
    end
  endtask

  task automatic test_single();
    tag_t tag;
    int   len;
    len = rand_len();
    request_read(tag);
    expect_region(tag, len);
    send_cpl(tag, 0, len, 1'b1);
    wait_drain();
  endtask

  task automatic test_split();
    tag_t tag;
    int   len [3];
    int   total;
    total = 0;
    for (int i = 0; i < 3; i++)
    begin
      len[i] = rand_len();
      total  = total + len[i];
    end
    request_read(tag);
    expect_region(tag, total);
    send_cpl(tag, 0, len[0], 1'b0);
    send_cpl(tag, len[0], len[1], 1'b0);
    send_cpl(tag, len[0] + len[1], len[2], 1'b1);
    wait_drain();
  endtask

  task automatic test_out_of_order();
    tag_t tag;
    tag_t tags [4];
    int   lens [4];
    int   order [4] = '{2, 0, 3, 1};
    for (int i = 0; i < 4; i++)
    begin
      request_read(tag);
      tags[i] = tag;
      lens[i] = rand_len();
      expect_region(tag, lens[i]);
    end
    for (int i = 0; i < 4; i++)
      send_cpl(tags[order[i]], 0, lens[order[i]], 1'b1);
    wait_drain();
  endtask

  task automatic test_wraparound();
    tag_t tag;
    tag_t tags [NUM_TAGS];
    int   lens [NUM_TAGS];
    int   rest;
    int   len;
    apply_reset();
    rest = 0;
    for (int i = 0; i < NUM_TAGS; i++)
    begin
      request_read(tag);
      tags[i] = tag;
      lens[i] = rand_len();
      expect_region(tag, lens[i]);
      if (i != 0)
        rest = rest + lens[i];
    end
    // all tags outstanding, this request is lost
    @(negedge avl_clk);
    check_bit(rd_grant, 1'b0, "grant with all tags outstanding");
    rd_req = 1'b1;
    @(negedge avl_clk);
    rd_req = 1'b0;
    send_cpl(tags[0], 0, lens[0], 1'b1);
    while (exp_data_q.size() > rest)
      @(negedge avl_clk);
    request_read(tag);
    len = rand_len();
    expect_region(tag, len);
    send_cpl(tag, 0, len, 1'b1);
    for (int i = NUM_TAGS - 1; i > 0; i--)
      send_cpl(tags[i], 0, lens[i], 1'b1);
    wait_drain();
  endtask

  // scoreboard check of every read data beat
  always @(posedge avl_clk)
  begin
    if (!rstn)
      mid_burst = 1'b0;
    else if (txs_valid)
    begin
      if (exp_data_q.size() == 0)
        abort_run($sformatf("ERR %0t: read data beat with nothing outstanding", $time));
      else
      begin
        beat_last = exp_last_q.pop_front();
        check_data(txs_data, exp_data_q.pop_front(), "read data");
        check_bit(uut.tag_release, beat_last, "tag release");
        mid_burst = !beat_last;
      end
    end
    else
      check_bit(txs_valid, mid_burst, "read data valid inside a burst");
  end

  initial
  begin
    repeat (WDOG_CYCLES) @(posedge avl_clk);
    abort_run("timeout: read data did not come out within the cycle limit");
  end

  initial
  begin
    apply_reset();
    test_reset();
    test_single();
    test_split();
    test_out_of_order();
    test_wraparound();
    repeat (10) @(negedge avl_clk);
    if (exp_data_q.size() != 0)
      abort_run($sformatf("ERR %0t: %0d expected beats never came out", $time,
                          exp_data_q.size()));
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* vlog.f */
hdl/cpl_pkg.sv
hdl/cpl_tag_alloc.sv
hdl/cpl_buf_ram.sv
hdl/cpl_wr_ctrl.sv
hdl/cpl_rx_resp.sv
hdl/cpl_read_top.sv
bench/cpl_read_assert.sv
bench/cpl_read_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cpl_read_tb -f vlog.f -o cpl_read_sim
./obj_dir/cpl_read_sim 2>&1 | tee sim.log

# the fail message or a missing verdict means the run failed
if grep -q "Finished with errors" sim.log || ! grep -q "Finished with no errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
